// File: design/cla_group.sv
`timescale 1ns/1ps
`default_nettype none

module cla_group #(
    parameter int GROUP_WIDTH = 4
) (
    input  logic [GROUP_WIDTH-1:0] x,
    input  logic [GROUP_WIDTH-1:0] y,
    input  logic                   cin,
    output logic [GROUP_WIDTH-1:0] sum,
    output logic                   cout
);

    logic [GROUP_WIDTH-1:0] gen;
    logic [GROUP_WIDTH-1:0] prop;
    logic [GROUP_WIDTH:0]   carry;

    assign gen  = x & y;
    assign prop = x ^ y;

    // carry into bit i+1 from g, p and the carry into bit i.
    always_comb begin
        carry[0] = cin;
        for (int i = 0; i < GROUP_WIDTH; i++) begin
            carry[i + 1] = gen[i] | (prop[i] & carry[i]);
        end
    end

    assign sum  = prop ^ carry[GROUP_WIDTH-1:0];
    assign cout = carry[GROUP_WIDTH];

endmodule

`default_nettype wire

// File: design/dadda_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module dadda_multiplier
    import dadda_pkg::*;
#(
    parameter int GROUP_WIDTH = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    output product_t product,
    output logic     out_valid
);

    pp_stage_t   pp_stage;
    rows_stage_t rows_stage;

    // stage 1, and matrix.
    partial_product_gen u_pp_gen (
        .clk     (clk),
        .rst     (rst),
        .in_valid(in_valid),
        .a       (a),
        .b       (b),
        .pp      (pp_stage)
    );

    // stage 2, columns down to two rows.
    dadda_reduce u_reduce (
        .clk (clk),
        .rst (rst),
        .pp  (pp_stage),
        .rows(rows_stage)
    );

    // stage 3, grouped lookahead add.
    final_adder #(
        .GROUP_WIDTH(GROUP_WIDTH)
    ) u_final_adder (
        .clk      (clk),
        .rst      (rst),
        .rows     (rows_stage),
        .product  (product),
        .out_valid(out_valid)
    );

endmodule

`default_nettype wire

// File: design/dadda_pkg.sv
`default_nettype none

package dadda_pkg;

    localparam int OPERAND_WIDTH = 8;
    localparam int PRODUCT_WIDTH = 2 * OPERAND_WIDTH;

    typedef logic [OPERAND_WIDTH-1:0] operand_t;
    typedef logic [PRODUCT_WIDTH-1:0] product_t;

    // row i is a anded with b[i].
    typedef struct packed {
        logic                         valid;
        operand_t [OPERAND_WIDTH-1:0] row;
    } pp_stage_t;

    typedef struct packed {
        logic     valid;
        product_t sum_row;
        product_t carry_row;
    } rows_stage_t;

    // returns {carry, sum}.
    function automatic logic [1:0] full_add(
        input logic x,
        input logic y,
        input logic z
    );
        logic s;
        logic c;
        s = x ^ y ^ z;
        c = (x & y) | (x & z) | (y & z); // majority.
        return {c, s};
    endfunction

    // returns {carry, sum}.
    function automatic logic [1:0] half_add(
        input logic x,
        input logic y
    );
        logic s;
        logic c;
        s = x ^ y;
        c = x & y;
        return {c, s};
    endfunction

endpackage

`default_nettype wire

// File: design/dadda_reduce.sv
`timescale 1ns/1ps
`default_nettype none

module dadda_reduce
    import dadda_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  pp_stage_t   pp,
    output rows_stage_t rows
);

    // largest Dadda number below h, the next target height.
    function automatic int dadda_height(input int h);
        int d;
        d = 2;
        while ((d * 3) / 2 < h) begin
            d = (d * 3) / 2;
        end
        return d;
    endfunction

    function automatic int count_stages(input int n);
        int h;
        int cnt;
        h   = n;
        cnt = 0;
        while (h > 2) begin
            h   = dadda_height(h);
            cnt = cnt + 1;
        end
        return cnt;
    endfunction

    localparam int NUM_STAGES = count_stages(OPERAND_WIDTH); // 4 for 8 bits.

    product_t sum_row;
    product_t carry_row;

    always_comb begin : reduce_tree
        logic [OPERAND_WIDTH-1:0] cur [PRODUCT_WIDTH];
        logic [OPERAND_WIDTH-1:0] nxt [PRODUCT_WIDTH];
        int                       cur_h [PRODUCT_WIDTH];
        int                       nxt_h [PRODUCT_WIDTH];
        int                       target;
        int                       excess;
        int                       fa_n;
        int                       ha_n;
        int                       k;
        logic [1:0]               sc;

        for (int c = 0; c < PRODUCT_WIDTH; c++) begin
            cur[c]   = '0;
            nxt[c]   = '0;
            cur_h[c] = 0;
            nxt_h[c] = 0;
        end
        sc = '0;

        // bit j of row i has weight i + j.
        for (int i = 0; i < OPERAND_WIDTH; i++) begin
            for (int j = 0; j < OPERAND_WIDTH; j++) begin
                cur[i + j][cur_h[i + j]] = pp.row[i][j];
                cur_h[i + j] += 1;
            end
        end

        target = OPERAND_WIDTH;
        for (int s = 0; s < NUM_STAGES; s++) begin
            target = dadda_height(target); // 6, 4, 3, 2.
            for (int c = 0; c < PRODUCT_WIDTH; c++) begin
                nxt[c]   = '0;
                nxt_h[c] = 0;
            end
            for (int c = 0; c < PRODUCT_WIDTH; c++) begin
                // carries from column c-1 already sit in nxt[c].
                excess = cur_h[c] + nxt_h[c] - target;
                fa_n   = (excess > 0) ? excess / 2 : 0;
                ha_n   = (excess > 0) ? excess % 2 : 0;
                k      = 0;
                for (int i = 0; i < OPERAND_WIDTH; i++) begin
                    if (i < fa_n + ha_n) begin
                        if (i < fa_n) begin
                            sc = full_add(cur[c][k], cur[c][k + 1], cur[c][k + 2]);
                            k += 3;
                        end else begin
                            sc = half_add(cur[c][k], cur[c][k + 1]);
                            k += 2;
                        end
                        nxt[c][nxt_h[c]] = sc[0];
                        nxt_h[c] += 1;
                        if (c + 1 < PRODUCT_WIDTH) begin
                            nxt[c + 1][nxt_h[c + 1]] = sc[1];
                            nxt_h[c + 1] += 1;
                        end
                    end
                end
                // untouched bits drop straight through.
                for (int i = 0; i < OPERAND_WIDTH; i++) begin
                    if (i >= k && i < cur_h[c]) begin
                        nxt[c][nxt_h[c]] = cur[c][i];
                        nxt_h[c] += 1;
                    end
                end
            end
            cur   = nxt;
            cur_h = nxt_h;
        end

        // at most two bits left per column, empty slots are zero.
        for (int c = 0; c < PRODUCT_WIDTH; c++) begin
            sum_row[c]   = cur[c][0];
            carry_row[c] = cur[c][1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rows.valid <= 1'b0;
        end else begin
            rows.valid <= pp.valid;
        end
        rows.sum_row   <= sum_row;
        rows.carry_row <= carry_row;
    end

endmodule

`default_nettype wire

// File: design/final_adder.sv
`timescale 1ns/1ps
`default_nettype none

module final_adder
    import dadda_pkg::*;
#(
    parameter int GROUP_WIDTH = 4
) (
    input  logic        clk,
    input  logic        rst,
    input  rows_stage_t rows,
    output product_t    product,
    output logic        out_valid
);

    localparam int NUM_GROUPS = PRODUCT_WIDTH / GROUP_WIDTH;

    logic [NUM_GROUPS-1:0] group_cin;
    product_t              sum;

    assign group_cin[0] = 1'b0;

    for (genvar g = 0; g < NUM_GROUPS; g++) begin : gen_group
        if (g < NUM_GROUPS - 1) begin : gen_mid
            cla_group #(
                .GROUP_WIDTH(GROUP_WIDTH)
            ) u_group (
                .x   (rows.sum_row[g*GROUP_WIDTH +: GROUP_WIDTH]),
                .y   (rows.carry_row[g*GROUP_WIDTH +: GROUP_WIDTH]),
                .cin (group_cin[g]),
                .sum (sum[g*GROUP_WIDTH +: GROUP_WIDTH]),
                .cout(group_cin[g + 1])                 // ripples to next group.
            );
        end else begin : gen_last
            // top carry is always zero, product fits in 16 bits.
            cla_group #(
                .GROUP_WIDTH(GROUP_WIDTH)
            ) u_group (
                .x   (rows.sum_row[g*GROUP_WIDTH +: GROUP_WIDTH]),
                .y   (rows.carry_row[g*GROUP_WIDTH +: GROUP_WIDTH]),
                .cin (group_cin[g]),
                .sum (sum[g*GROUP_WIDTH +: GROUP_WIDTH]),
                .cout()
            );
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= rows.valid;
        end
        product <= sum;
    end

endmodule

`default_nettype wire

// File: design/partial_product_gen.sv
`timescale 1ns/1ps
`default_nettype none

module partial_product_gen
    import dadda_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_valid,
    input  operand_t  a,
    input  operand_t  b,
    output pp_stage_t pp
);

    operand_t [OPERAND_WIDTH-1:0] matrix;

    // one and gate per bit pair.
    always_comb begin
        for (int i = 0; i < OPERAND_WIDTH; i++) begin
            matrix[i] = a & {OPERAND_WIDTH{b[i]}};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pp.valid <= 1'b0;
        end else begin
            pp.valid <= in_valid;
        end
        pp.row <= matrix; // no reset on the matrix.
    end

endmodule

`default_nettype wire

// File: test/product_checker.sv
`timescale 1ns/1ps
`default_nettype none

module product_checker
    import dadda_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  operand_t a,
    input  operand_t b,
    input  logic     out_valid,
    input  product_t product,
    output int       error_count,
    output int       checked_count,
    output int       pending_count
);

    typedef struct packed {
        operand_t    op_a;
        operand_t    op_b;
        int unsigned expected;
        int unsigned due;
    } pending_t;

    pending_t    fifo [$];
    pending_t    head;
    int unsigned cycle = 0;
    logic        reset_seen = 1'b0;
    int          errors = 0;
    int          checked = 0;
    int          pending = 0;

    assign error_count   = errors;
    assign checked_count = checked;
    assign pending_count = pending;

    // outputs are read before this edge's register updates land.
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (reset_seen && $isunknown(out_valid)) begin
            $display("out_valid is unknown at %0t after reset", $time);
            errors++;
        end else if (out_valid === 1'b1) begin
            if (fifo.size() == 0) begin
                $display("out_valid went high at %0t with no input waiting for a result",
                         $time);
                errors++;
            end else begin
                head = fifo.pop_front();
                checked++;
                if (cycle != head.due) begin
                    $display("FAILED at %0t: result for %0d * %0d came at cycle %0d, due at %0d",
                             $time, head.op_a, head.op_b, cycle, head.due);
                    errors++;
                end else if (product !== head.expected[PRODUCT_WIDTH-1:0]) begin
                    $display("FAILED at %0t: %0d * %0d expected %0d, got %0d",
                             $time, head.op_a, head.op_b, head.expected, product);
                    errors++;
                end
            end
        end else if (fifo.size() > 0 && fifo[0].due <= cycle) begin
            head = fifo.pop_front(); // dropped so later results still line up.
            $display("no result at %0t for %0d * %0d, out_valid stayed low",
                     $time, head.op_a, head.op_b);
            errors++;
        end

        if (rst === 1'b1) begin
            fifo.delete(); // everything in flight is lost.
            reset_seen = 1'b1;
        end else if (in_valid === 1'b1) begin
            head.op_a     = a;
            head.op_b     = b;
            head.expected = int'(a) * int'(b);
            head.due      = cycle + 3;
            fifo.push_back(head);
        end
        pending = fifo.size();
    end

endmodule

`default_nettype wire

// File: test/tb_dadda_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dadda_multiplier
    import dadda_pkg::*;
();

    localparam int DRAIN_TIMEOUT = 20;

    logic     clk;
    logic     rst;
    logic     in_valid;
    operand_t a;
    operand_t b;
    product_t product;
    logic     out_valid;

    int       error_count;
    int       checked_count;
    int       pending_count;
    int       seed;
    int       tb_errors;
    int       tests_ok;
    int       tests_bad;
    operand_t corners [12];

    dadda_multiplier #(
        .GROUP_WIDTH(4)
    ) UUT (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .product  (product),
        .out_valid(out_valid)
    );

    product_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .a            (a),
        .b            (b),
        .out_valid    (out_valid),
        .product      (product),
        .error_count  (error_count),
        .checked_count(checked_count),
        .pending_count(pending_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period.
    end

    function automatic operand_t random_operand();
        int r;
        r = $random(seed);
        return r[OPERAND_WIDTH-1:0];
    endfunction

    function automatic logic random_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    task automatic drive_pair(input operand_t x, input operand_t y, input logic v);
        @(negedge clk);
        a        = x;
        b        = y;
        in_valid = v;
    endtask

    task automatic drive_idle();
        drive_pair('0, '0, 1'b0);
    endtask

    task automatic wait_for_drain(input string name);
        int n;
        drive_idle(); // last pair gets sampled first.
        n = 0;
        while (pending_count != 0 && n < DRAIN_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (pending_count != 0) begin
            $display("%s: drain timed out with %0d results still pending", name, pending_count);
            tb_errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        int errors_now;
        errors_now = error_count + tb_errors;
        if (errors_now == errors_before) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
        $display("[%s] done, %0d errors", name, errors_now - errors_before);
    endtask

    task automatic reset_test();
        int errors_before;
        errors_before = error_count + tb_errors;
        // nothing sampled yet, so out_valid stays low.
        for (int i = 0; i < 5; i++) begin
            drive_idle();
            if (out_valid !== 1'b0) begin
                $display("FAILED at %0t: out_valid is %b while idle after reset",
                         $time, out_valid);
                tb_errors++;
            end
        end
        for (int i = 0; i < 20; i++) begin
            drive_pair(random_operand(), random_operand(), 1'b1);
        end
        @(negedge clk);
        rst = 1'b1; // pairs in flight are cleared.
        @(negedge clk);
        rst = 1'b0;
        if (out_valid !== 1'b0) begin
            $display("FAILED at %0t: out_valid is %b right after reset",
                     $time, out_valid);
            tb_errors++;
        end
        for (int i = 0; i < 10; i++) begin
            drive_pair(random_operand(), random_operand(), 1'b1);
        end
        wait_for_drain("reset");
        report_test("reset", errors_before);
    endtask

    task automatic random_test();
        int errors_before;
        errors_before = error_count + tb_errors;
        for (int i = 0; i < 300; i++) begin
            drive_pair(random_operand(), random_operand(), 1'b1);
        end
        wait_for_drain("random");
        report_test("random", errors_before);
    endtask

    task automatic corner_test();
        int errors_before;
        errors_before = error_count + tb_errors;
        for (int i = 0; i < 12; i++) begin
            for (int j = 0; j < 12; j++) begin
                drive_pair(corners[i], corners[j], 1'b1);
            end
        end
        wait_for_drain("corner");
        report_test("corner", errors_before);
    endtask

    task automatic sparse_test();
        int errors_before;
        int checked_before;
        int inputs_sent;
        logic v;
        errors_before  = error_count + tb_errors;
        checked_before = checked_count;
        inputs_sent    = 0;
        for (int i = 0; i < 300; i++) begin
            v = random_bit();
            if (v) begin
                inputs_sent++;
            end
            drive_pair(random_operand(), random_operand(), v);
        end
        wait_for_drain("sparse");
        if (checked_count - checked_before != inputs_sent) begin
            $display("FAILED at %0t: %0d results for %0d inputs",
                     $time, checked_count - checked_before, inputs_sent);
            tb_errors++;
        end
        report_test("sparse", errors_before);
    endtask

    initial begin
        seed      = 32'h1d17880b;
        rst       = 1'b1;
        in_valid  = 1'b0;
        a         = '0;
        b         = '0;
        tb_errors = 0;
        tests_ok  = 0;
        tests_bad = 0;
        corners   = '{8'd0, 8'd1, 8'd2, 8'd4, 8'd8, 8'd16, 8'd32, 8'd64,
                      8'd128, 8'd255, 8'h55, 8'haa};

        repeat (3) @(negedge clk);
        rst = 1'b0;

        reset_test();
        random_test();
        corner_test();
        sparse_test();
        repeat (4) drive_idle(); // catches stray results.

        $display("summary: %0d tests ok, %0d tests with errors, %0d products checked",
                 tests_ok, tests_bad, checked_count);
        if (tests_bad == 0 && error_count + tb_errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: vlog.f
design/dadda_pkg.sv
design/partial_product_gen.sv
design/dadda_reduce.sv
design/cla_group.sv
design/final_adder.sv
design/dadda_multiplier.sv
test/product_checker.sv
test/tb_dadda_multiplier.sv
